/* hdl/ebus_defs.svh */
`ifndef EBUS_DEFS_SVH
`define EBUS_DEFS_SVH

// EBUS data word width, numbered 0 (MSB) to 35 (LSB)
`define EBUS_WIDTH 36

// Units that can place data on the EBUS
`define NUM_DRIVERS 3

// Device codes compared against cs
`define DEV_APR 3'd0
`define DEV_PI 3'd1
`define DEV_MTR 3'd2

// CONO word control bits
`define CONO_CLR 22
`define CONO_SET 23

// The PI assignment field occupies three bits starting here
`define PIA_LSB 33

`endif

/* hdl/ebusPkg.sv */
`default_nettype none

`include "ebus_defs.svh"

package ebusPkg;

  // Bit 0 is the most significant bit, following PDP-10 numbering
  typedef logic [0:`EBUS_WIDTH-1] ebusWord_t;

  // The four EBUS transfer kinds issued by the EBOX
  typedef enum logic [1:0] {
    FUNC_CONO  = 2'd0,
    FUNC_CONI  = 2'd1,
    FUNC_DATAO = 2'd2,
    FUNC_DATAI = 2'd3
  } ebusFunc_t;

  // Interrupt level, 1 is the highest priority and 0 means no request
  typedef logic [2:0] piLevel_t;

endpackage

`default_nettype wire

/* hdl/ebusMux.sv */
`default_nettype none

`include "ebus_defs.svh"

module ebusMux (
  input  logic               clk,
  input  logic               rst,
  input  logic               drivingApr,
  input  logic               drivingPi,
  input  logic               drivingMtr,
  input  ebusPkg::ebusWord_t dataApr,
  input  ebusPkg::ebusWord_t dataPi,
  input  ebusPkg::ebusWord_t dataMtr,
  output ebusPkg::ebusWord_t ebusData,
  output logic               readValid,
  output logic               conflict
);

  logic [`NUM_DRIVERS-1:0] drivers;

  assign drivers = {drivingApr, drivingPi, drivingMtr};

  // Fixed priority, APR wins over PI and PI over the meter
  always_comb begin
    if (drivingApr) begin
      ebusData = dataApr;
    end else if (drivingPi) begin
      ebusData = dataPi;
    end else if (drivingMtr) begin
      ebusData = dataMtr;
    end else begin
      ebusData = '0;
    end
  end

  assign readValid = |drivers;

  // More than one bit set means two units answered the same cycle
  assign conflict = (drivers & (drivers - 1'b1)) != '0;

  // Units decode distinct device codes, so their responses must never overlap
  assert property (@(posedge clk) disable iff (rst) $onehot0(drivers))
    else $error("EBUS driver contention, drivers = %b", drivers);

endmodule

`default_nettype wire

/* hdl/aprUnit.sv */
`default_nettype none

`include "ebus_defs.svh"

module aprUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               demand,
  input  logic [2:0]         cs,
  input  ebusPkg::ebusFunc_t func,
  input  ebusPkg::ebusWord_t dataIn,
  output logic               driving,
  output ebusPkg::ebusWord_t dataOut,
  output ebusPkg::piLevel_t  aprReq
);

  import ebusPkg::*;

  logic       selected;
  logic [0:7] flags;
  logic [0:7] flagMask;
  logic [0:7] clrMask;
  logic [0:7] setMask;
  piLevel_t   pia;
  ebusWord_t  breakAddr;
  ebusWord_t  coniWord;

  assign selected = demand && (cs == `DEV_APR);

  // Flags live in bits 24 to 31 of both the CONO and CONI words
  assign flagMask = dataIn[24:31];
  assign clrMask  = dataIn[`CONO_CLR] ? flagMask : 8'h00;
  assign setMask  = dataIn[`CONO_SET] ? flagMask : 8'h00;

  always_comb begin
    coniWord = '0;
    coniWord[24:31] = flags;
    coniWord[`PIA_LSB +: 3] = pia;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags     <= '0;
      pia       <= '0;
      breakAddr <= '0;
      driving   <= 1'b0;
      dataOut   <= '0;
      aprReq    <= '0;
    end else begin
      driving <= 1'b0;
      // Any raised flag requests an interrupt on the assigned level
      aprReq  <= (|flags) ? pia : '0;
      if (selected) begin
        case (func)
          FUNC_CONO: begin
            // Clear is applied before set, so a word with both bits sets the flags
            flags <= (flags & ~clrMask) | setMask;
            pia   <= dataIn[`PIA_LSB +: 3];
          end
          FUNC_CONI: begin
            driving <= 1'b1;
            dataOut <= coniWord;
          end
          FUNC_DATAO: begin
            breakAddr <= dataIn;
          end
          FUNC_DATAI: begin
            driving <= 1'b1;
            dataOut <= breakAddr;
          end
          default: begin
            driving <= 1'b0;
          end
        endcase
      end
    end
  end

  // Demand is a one-cycle strobe, so a read answers for a single cycle
  assert property (@(posedge clk) disable iff (rst) driving |=> !driving)
    else $error("APR drove the EBUS for two cycles in a row");

endmodule

`default_nettype wire

/* hdl/piUnit.sv */
`default_nettype none

`include "ebus_defs.svh"

module piUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               demand,
  input  logic [2:0]         cs,
  input  ebusPkg::ebusFunc_t func,
  input  ebusPkg::ebusWord_t dataIn,
  input  ebusPkg::piLevel_t  aprReq,
  input  ebusPkg::piLevel_t  mtrReq,
  output logic               driving,
  output ebusPkg::ebusWord_t dataOut,
  output ebusPkg::piLevel_t  piLevel
);

  import ebusPkg::*;

  localparam int SysOnBit  = 24;
  localparam int SysOffBit = 25;

  logic       selected;
  logic [1:7] enables;
  logic [1:7] enablesNext;
  logic [1:7] requests;
  logic [1:7] active;
  logic       sysOn;
  logic       sysOnNext;
  ebusWord_t  coniWord;

  // One-hot request bit for a level where level 0 sets no bit
  function automatic logic [1:7] levelBit(input piLevel_t lvl);
    logic [1:7] bits;
    bits = '0;
    if (lvl != 3'd0) begin
      bits[lvl] = 1'b1;
    end
    return bits;
  endfunction

  // Scanning down from 7 leaves the lowest active level as the result
  function automatic piLevel_t encodeLevel(input logic [1:7] act);
    piLevel_t lvl;
    lvl = '0;
    for (int i = 7; i >= 1; i--) begin
      if (act[i]) begin
        lvl = piLevel_t'(i);
      end
    end
    return lvl;
  endfunction

  assign selected = demand && (cs == `DEV_PI);
  assign requests = levelBit(aprReq) | levelBit(mtrReq);

  // The next enable state lets a CONO reach piLevel on the same edge it is applied
  always_comb begin
    enablesNext = enables;
    sysOnNext   = sysOn;
    if (selected && func == FUNC_CONO) begin
      if (dataIn[`CONO_CLR]) begin
        enablesNext = enablesNext & ~dataIn[29:35];
      end
      if (dataIn[`CONO_SET]) begin
        enablesNext = enablesNext | dataIn[29:35];
      end
      if (dataIn[SysOffBit]) begin
        sysOnNext = 1'b0;
      end
      if (dataIn[SysOnBit]) begin
        sysOnNext = 1'b1;
      end
    end
  end

  assign active = requests & enablesNext & {7{sysOnNext}};

  always_comb begin
    coniWord = '0;
    coniWord[11:17] = requests;
    coniWord[28] = sysOn;
    coniWord[29:35] = enables;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enables <= '0;
      sysOn   <= 1'b0;
      piLevel <= '0;
      driving <= 1'b0;
      dataOut <= '0;
    end else begin
      enables <= enablesNext;
      sysOn   <= sysOnNext;
      piLevel <= encodeLevel(active);
      driving <= selected && (func == FUNC_CONI || func == FUNC_DATAI);
      if (selected && func == FUNC_CONI) begin
        dataOut <= coniWord;
      end else if (selected && func == FUNC_DATAI) begin
        // DATAI has no data register behind it but the bus still sees a response
        dataOut <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mtrUnit.sv */
`default_nettype none

`include "ebus_defs.svh"

module mtrUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               demand,
  input  logic [2:0]         cs,
  input  ebusPkg::ebusFunc_t func,
  input  ebusPkg::ebusWord_t dataIn,
  output logic               driving,
  output ebusPkg::ebusWord_t dataOut,
  output ebusPkg::piLevel_t  mtrReq
);

  import ebusPkg::*;

  localparam int EnableBit  = 30;
  localparam int ClrDoneBit = 31;
  localparam int DoneBit    = 32;

  logic        selected;
  logic [15:0] period;
  logic [15:0] counter;
  logic        enable;
  logic        done;
  piLevel_t    pia;
  ebusWord_t   coniWord;
  ebusWord_t   dataiWord;

  assign selected = demand && (cs == `DEV_MTR);

  always_comb begin
    coniWord = '0;
    coniWord[EnableBit] = enable;
    coniWord[DoneBit] = done;
    coniWord[`PIA_LSB +: 3] = pia;
  end

  // Counter is right-justified in the same field the period is loaded from
  always_comb begin
    dataiWord = '0;
    dataiWord[20:35] = counter;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      period  <= '0;
      counter <= '0;
      enable  <= 1'b0;
      done    <= 1'b0;
      pia     <= '0;
      driving <= 1'b0;
      dataOut <= '0;
      mtrReq  <= '0;
    end else begin
      driving <= 1'b0;
      mtrReq  <= done ? pia : '0;
      // The interval is period + 1 cycles since the count includes zero
      if (enable) begin
        if (counter == period) begin
          counter <= '0;
          done    <= 1'b1;
        end else begin
          counter <= counter + 16'd1;
        end
      end
      if (selected) begin
        case (func)
          FUNC_CONO: begin
            enable <= dataIn[EnableBit];
            pia    <= dataIn[`PIA_LSB +: 3];
            // Placed after the count so a clear wins over a wrap on the same edge
            if (dataIn[ClrDoneBit]) begin
              done <= 1'b0;
            end
          end
          FUNC_CONI: begin
            driving <= 1'b1;
            dataOut <= coniWord;
          end
          FUNC_DATAO: begin
            period <= dataIn[20:35];
          end
          FUNC_DATAI: begin
            driving <= 1'b1;
            dataOut <= dataiWord;
          end
          default: begin
            driving <= 1'b0;
          end
        endcase
      end
    end
  end

  // A shorter period loaded while the meter runs would let the count pass it
  assert property (@(posedge clk) disable iff (rst) enable |-> counter <= period)
    else $error("Meter count passed the period while the meter was running");

endmodule

`default_nettype wire

/* hdl/ebusTop.sv */
`default_nettype none

module ebusTop (
  input  logic               clk,
  input  logic               rst,
  input  logic               demand,
  input  logic [2:0]         cs,
  input  ebusPkg::ebusFunc_t func,
  input  ebusPkg::ebusWord_t dataIn,
  output ebusPkg::ebusWord_t ebusData,
  output logic               readValid,
  output logic               conflict,
  output ebusPkg::piLevel_t  piLevel
);

  import ebusPkg::*;

  // Each unit presents a driving level and a word, the mux picks one
  logic      drivingApr;
  logic      drivingPi;
  logic      drivingMtr;
  ebusWord_t dataApr;
  ebusWord_t dataPi;
  ebusWord_t dataMtr;

  // Interrupt requests from the requesting units into PI
  piLevel_t  aprReq;
  piLevel_t  mtrReq;

  aprUnit apr0 (
    .clk(clk), .rst(rst), .demand(demand), .cs(cs), .func(func), .dataIn(dataIn),
    .driving(drivingApr), .dataOut(dataApr), .aprReq(aprReq)
  );

  piUnit pi0 (
    .clk(clk), .rst(rst), .demand(demand), .cs(cs), .func(func), .dataIn(dataIn),
    .aprReq(aprReq), .mtrReq(mtrReq),
    .driving(drivingPi), .dataOut(dataPi), .piLevel(piLevel)
  );

  mtrUnit mtr0 (
    .clk(clk), .rst(rst), .demand(demand), .cs(cs), .func(func), .dataIn(dataIn),
    .driving(drivingMtr), .dataOut(dataMtr), .mtrReq(mtrReq)
  );

  ebusMux mux0 (
    .clk(clk),
    .rst(rst),
    .drivingApr(drivingApr),
    .drivingPi(drivingPi),
    .drivingMtr(drivingMtr),
    .dataApr(dataApr),
    .dataPi(dataPi),
    .dataMtr(dataMtr),
    .ebusData(ebusData),
    .readValid(readValid),
    .conflict(conflict)
  );

endmodule

`default_nettype wire

/* bench/ebusTb.sv */
`default_nettype none

`include "ebus_defs.svh"

module ebusTb;

  import ebusPkg::*;

  localparam int ReadTimeout = 8;
  localparam int PollLimit   = 64;
  localparam int MtrEnableBit  = 30;
  localparam int MtrClrDoneBit = 31;
  localparam int MtrDoneBit    = 32;
  localparam int PiSysOnBit    = 24;
  localparam int PiSysOffBit   = 25;

  logic      clk;
  logic      rst;
  logic      demand;
  logic [2:0] cs;
  ebusFunc_t func;
  ebusWord_t dataIn;
  ebusWord_t ebusData;
  logic      readValid;
  logic      conflict;
  piLevel_t  piLevel;

  // Reference state kept by the bench
  logic [31:0] lfsrState;
  logic [7:0]  aprFlags;
  piLevel_t    aprPia;
  piLevel_t    mtrPia;
  logic [1:7]  piEnables;
  logic [15:0] period;
  logic [7:0]  mask;
  logic [1:0]  ctl;
  piLevel_t    pia;
  ebusWord_t   breakWord;
  ebusWord_t   w;

  ebusTop dut0 (
    .clk(clk), .rst(rst), .demand(demand), .cs(cs), .func(func), .dataIn(dataIn),
    .ebusData(ebusData), .readValid(readValid), .conflict(conflict), .piLevel(piLevel)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [35:0] randomBits(input int n);
    logic [35:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[34:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic ebusWord_t aprConiWord(input logic [7:0] flags, input piLevel_t p);
    ebusWord_t r;
    r = '0;
    r[24:31] = flags;
    r[`PIA_LSB +: 3] = p;
    return r;
  endfunction

  function automatic ebusWord_t mtrConiWord(input logic dn, input logic en, input piLevel_t p);
    ebusWord_t r;
    r = '0;
    r[MtrDoneBit] = dn;
    r[MtrEnableBit] = en;
    r[`PIA_LSB +: 3] = p;
    return r;
  endfunction

  // Request bit for level L sits at 10 + L, the enable for level L at 28 + L
  function automatic ebusWord_t piConiWord(input piLevel_t reqA, input piLevel_t reqB,
                                           input logic [1:7] en, input logic on);
    ebusWord_t r;
    r = '0;
    if (reqA != 3'd0) begin
      r[10 + reqA] = 1'b1;
    end
    if (reqB != 3'd0) begin
      r[10 + reqB] = 1'b1;
    end
    r[28] = on;
    r[29:35] = en;
    return r;
  endfunction

  task automatic failValue(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    $display("Errors found");
    $fatal(1, "Stopped on a wrong value");
  endtask

  task automatic failTimeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Errors found");
    $fatal(1, "Stopped on a timeout");
  endtask

  task automatic checkWord(input string what, input ebusWord_t got, input ebusWord_t exp);
    assert (got === exp)
      else failValue($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  // Every transfer starts and ends 10 time units after a rising edge
  task automatic writeWord(input logic [2:0] dev, input ebusFunc_t f, input ebusWord_t word);
    demand = 1'b1;
    cs = dev;
    func = f;
    dataIn = word;
    @(posedge clk);
    #10;
    demand = 1'b0;
    dataIn = '0;
  endtask

  task automatic readWord(input logic [2:0] dev, input ebusFunc_t f, output ebusWord_t word);
    int waited;
    demand = 1'b1;
    cs = dev;
    func = f;
    dataIn = '0;
    @(posedge clk);
    #10;
    demand = 1'b0;
    waited = 1;
    while (!readValid && waited < ReadTimeout) begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (!readValid) begin
      failTimeout("readValid after a read demand");
    end else begin
      word = ebusData;
    end
  endtask

  task automatic waitLevel(input piLevel_t exp, input int limit, input string what);
    int waited;
    waited = 0;
    while (piLevel !== exp && waited < limit) begin
      @(posedge clk);
      #10;
      waited++;
    end
    assert (piLevel === exp)
      else failValue($sformatf("%s: piLevel %0d, expected %0d", what, piLevel, exp));
  endtask

  task automatic pollMeterDone(output ebusWord_t word);
    int polls;
    polls = 0;
    readWord(`DEV_MTR, FUNC_CONI, word);
    while (!word[MtrDoneBit] && polls < PollLimit) begin
      readWord(`DEV_MTR, FUNC_CONI, word);
      polls++;
    end
    if (!word[MtrDoneBit]) begin
      failTimeout("the meter done flag in CONI");
    end
  endtask

  assert property (@(posedge clk) disable iff (rst) !conflict)
    else failValue("conflict raised on the EBUS");

  // A read of a real unit answers exactly one cycle after demand
  assert property (@(posedge clk) disable iff (rst)
      (demand && cs <= `DEV_MTR && (func == FUNC_CONI || func == FUNC_DATAI)) |=> readValid)
    else failValue("readValid missing one cycle after a read demand");

  assert property (@(posedge clk) disable iff (rst)
      (demand && cs == 3'd3) |=> (!readValid && ebusData == '0))
    else failValue("unused device code 3 answered on the EBUS");

  initial begin
    rst = 1'b1;
    demand = 1'b0;
    cs = 3'd0;
    func = FUNC_CONO;
    dataIn = '0;
    lfsrState = 32'h82f0;
    aprFlags = '0;
    aprPia = '0;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;
    assert (!readValid && !conflict && piLevel == 3'd0)
      else failValue("outputs not cleared by reset");

    // APR flags with random masks, clear applied before set
    for (int i = 0; i < 6; i++) begin
      mask = 8'(randomBits(8));
      ctl = 2'(randomBits(2));
      pia = piLevel_t'(randomBits(3));
      w = '0;
      w[24:31] = mask;
      w[`CONO_CLR] = ctl[1];
      w[`CONO_SET] = ctl[0];
      w[`PIA_LSB +: 3] = pia;
      writeWord(`DEV_APR, FUNC_CONO, w);
      if (ctl[1]) aprFlags = aprFlags & ~mask;
      if (ctl[0]) aprFlags = aprFlags | mask;
      aprPia = pia;
      readWord(`DEV_APR, FUNC_CONI, w);
      checkWord("APR CONI", w, aprConiWord(aprFlags, aprPia));
    end
    // PI is still off, so requests must not reach piLevel
    assert (piLevel == 3'd0) else failValue("piLevel set while PI is off");

    breakWord = ebusWord_t'(randomBits(36));
    writeWord(`DEV_APR, FUNC_DATAO, breakWord);
    readWord(`DEV_APR, FUNC_DATAI, w);
    checkWord("APR address break", w, breakWord);

    demand = 1'b1;
    cs = 3'd3;
    func = FUNC_CONI;
    @(posedge clk);
    #10;
    demand = 1'b0;
    assert (!readValid && ebusData == '0) else failValue("read of device 3 drove the EBUS");

    // Silence APR so only the meter requests
    w = '0;
    w[24:31] = 8'hff;
    w[`CONO_CLR] = 1'b1;
    writeWord(`DEV_APR, FUNC_CONO, w);
    aprFlags = '0;
    aprPia = '0;
    w = '0;
    w[29:35] = 7'h7f;
    w[`CONO_SET] = 1'b1;
    w[PiSysOnBit] = 1'b1;
    writeWord(`DEV_PI, FUNC_CONO, w);
    piEnables = 7'h7f;
    waitLevel(3'd0, 2, "PI on with no requests");

    period = 16'(randomBits(4)) + 16'd3;
    w = '0;
    w[20:35] = period;
    writeWord(`DEV_MTR, FUNC_DATAO, w);
    mtrPia = 3'd3;
    w = '0;
    w[MtrEnableBit] = 1'b1;
    w[MtrClrDoneBit] = 1'b1;
    w[`PIA_LSB +: 3] = mtrPia;
    writeWord(`DEV_MTR, FUNC_CONO, w);
    readWord(`DEV_MTR, FUNC_CONI, w);
    checkWord("meter CONI after enable", w, mtrConiWord(1'b0, 1'b1, mtrPia));
    readWord(`DEV_MTR, FUNC_DATAI, w);
    assert (w[0:19] == '0 && w[20:35] <= period)
      else failValue($sformatf("meter count %h beyond period %0d", w, period));
    pollMeterDone(w);
    checkWord("meter CONI at done", w, mtrConiWord(1'b1, 1'b1, mtrPia));
    waitLevel(mtrPia, 3, "meter request at PI");
    w = '0;
    w[MtrClrDoneBit] = 1'b1;
    w[`PIA_LSB +: 3] = mtrPia;
    writeWord(`DEV_MTR, FUNC_CONO, w);
    waitLevel(3'd0, 2, "piLevel after clearing meter done");

    // APR on level 5 against the meter on level 2
    w = '0;
    w[31] = 1'b1;
    w[`CONO_SET] = 1'b1;
    w[`PIA_LSB +: 3] = 3'd5;
    writeWord(`DEV_APR, FUNC_CONO, w);
    aprFlags = 8'h01;
    aprPia = 3'd5;
    readWord(`DEV_APR, FUNC_CONI, w);
    checkWord("APR CONI on level 5", w, aprConiWord(aprFlags, aprPia));
    mtrPia = 3'd2;
    w = '0;
    w[MtrEnableBit] = 1'b1;
    w[`PIA_LSB +: 3] = mtrPia;
    writeWord(`DEV_MTR, FUNC_CONO, w);
    pollMeterDone(w);
    waitLevel(3'd2, 3, "level 2 over level 5");

    w = '0;
    w[30] = 1'b1;
    w[`CONO_CLR] = 1'b1;
    writeWord(`DEV_PI, FUNC_CONO, w);
    piEnables[2] = 1'b0;
    waitLevel(3'd5, 2, "level 5 after disabling level 2");
    readWord(`DEV_PI, FUNC_CONI, w);
    checkWord("PI CONI", w, piConiWord(3'd2, 3'd5, piEnables, 1'b1));

    w = '0;
    w[PiSysOffBit] = 1'b1;
    writeWord(`DEV_PI, FUNC_CONO, w);
    waitLevel(3'd0, 2, "piLevel with the system off");
    readWord(`DEV_PI, FUNC_CONI, w);
    checkWord("PI CONI with system off", w, piConiWord(3'd2, 3'd5, piEnables, 1'b0));
    readWord(`DEV_PI, FUNC_DATAI, w);
    checkWord("PI DATAI", w, '0);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* ebusTop.f */
+incdir+hdl
hdl/ebusPkg.sv
hdl/ebusMux.sv
hdl/aprUnit.sv
hdl/piUnit.sv
hdl/mtrUnit.sv
hdl/ebusTop.sv
bench/ebusTb.sv

/* Bender.yml */
package:
  name: ebus_subsystem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ebusPkg.sv
      - hdl/ebusMux.sv
      - hdl/aprUnit.sv
      - hdl/piUnit.sv
      - hdl/mtrUnit.sv
      - hdl/ebusTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/ebusTb.sv
